/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rsa_core_tb
FLIST     := rsa_core.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* bench/rsa_core_assertions.sv */
`timescale 1ns/100ps

// port-level checks on the matrix core
module rsa_core_assertions #(
  parameter int X = rsa_data_pkg::DEF_X,
  parameter int Y = rsa_data_pkg::DEF_Y
) (
  input logic                   clk,
  input logic                   sys_rst,
  input rsa_ctrl_pkg::pe_ctrl_t i_pe_ctrl,
  input logic [X-1:0]           o_c_val
);

  // consecutive valid cycles per row
  int run_len [X];

  always_ff @(posedge clk) begin
    for (int i = 0; i < X; i++) begin
      if (sys_rst || !o_c_val[i]) begin
        run_len[i] <= 0;
      end else begin
        run_len[i] <= run_len[i] + 1;
      end
    end
  end

  a_val_known: assert property (@(posedge clk) disable iff (sys_rst) !$isunknown(o_c_val))
    else $error("o_c_val is unknown");

  a_strobe_excl: assert property (@(posedge clk) !(i_pe_ctrl.cal_en && i_pe_ctrl.cal_done))
    else $error("cal_en and cal_done high together");

  // one drain burst is at most Y words
  for (genvar i = 0; i < X; i++) begin : g_row
    a_burst_len: assert property (@(posedge clk) disable iff (sys_rst) run_len[i] <= Y)
      else $error("row %0d valid longer than %0d cycles", i, Y);
  end

endmodule

bind rsa_core rsa_core_assertions #(
  .X (X),
  .Y (Y)
) u_rsa_core_assertions (
  .clk       (clk),
  .sys_rst   (sys_rst),
  .i_pe_ctrl (i_pe_ctrl),
  .o_c_val   (o_c_val)
);

/* bench/rsa_core_tb.sv */
`timescale 1ns/100ps

module rsa_core_tb;

  localparam int X = 2;
  localparam int Y = 2;
  localparam int NRUN = 9;
  localparam int MAXS = 4;
  localparam int TIMEOUT = 200;

  typedef struct packed {
    rsa_ctrl_pkg::pe_mode_e mode;
    rsa_ctrl_pkg::src_sel_e a_sel;
    rsa_ctrl_pkg::src_sel_e b_sel;
    rsa_ctrl_pkg::src_sel_e m_sel;
    int                     len;
    bit                     b2b;
  } run_t;

  logic                              clk = 1'b0;
  logic                              sys_rst = 1'b1;
  rsa_data_pkg::data_t [X-1:0]       a_temp, a_cov, m_temp, m_cov, c_out;
  rsa_data_pkg::data_t [Y-1:0]       b_temp, b_cov;
  rsa_ctrl_pkg::operand_sel_t        sel;
  logic                              load, cache_we;
  logic [rsa_data_pkg::CACHE_AW-1:0] cache_addr;
  rsa_ctrl_pkg::pe_ctrl_t            pe_ctrl;
  logic [X-1:0]                      c_val;

  run_t runs [NRUN];
  // operand values per run and step for both lane sets
  rsa_data_pkg::data_t a_t [NRUN][MAXS][X];
  rsa_data_pkg::data_t a_c [NRUN][MAXS][X];
  rsa_data_pkg::data_t b_t [NRUN][MAXS][Y];
  rsa_data_pkg::data_t b_c [NRUN][MAXS][Y];
  rsa_data_pkg::data_t m_t [NRUN][X];
  rsa_data_pkg::data_t m_c [NRUN][X];
  logic [rsa_data_pkg::CACHE_AW-1:0] caddr [NRUN][MAXS];
  rsa_data_pkg::data_t cache_model [Y][2**rsa_data_pkg::CACHE_AW];
  // expected words per row
  // run r column j sits at r*Y+j
  rsa_data_pkg::data_t exp_c [X][NRUN*Y];
  int run_err [NRUN];

  logic [15:0]            lfsr_state = 16'd7766;
  bit                     done_pending = 1'b0;
  rsa_ctrl_pkg::pe_mode_e pending_mode = rsa_ctrl_pkg::MODE_ACC;
  int errors = 0;
  int tests_failed = 0;

  rsa_core #(.X(X), .Y(Y)) dut (
    .clk(clk), .sys_rst(sys_rst),
    .i_a_temp(a_temp), .i_a_cov(a_cov), .i_m_temp(m_temp), .i_m_cov(m_cov),
    .i_b_temp(b_temp), .i_b_cov(b_cov), .i_sel(sel), .i_load(load),
    .i_cache_we(cache_we), .i_cache_addr(cache_addr), .i_pe_ctrl(pe_ctrl),
    .o_c(c_out), .o_c_val(c_val)
  );

  always #10 clk = ~clk;

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // 10-bit signed operand
  // products of two still overflow 16 bits
  function rsa_data_pkg::data_t rand_word();
    logic [15:0] r;
    r = take_bits(10);
    return {{6{r[9]}}, r[9:0]};
  endfunction

  function automatic rsa_data_pkg::data_t source_word(input rsa_ctrl_pkg::src_sel_e s,
      input rsa_data_pkg::data_t t, input rsa_data_pkg::data_t c,
      input rsa_data_pkg::data_t v);
    case (s)
      rsa_ctrl_pkg::SRC_TEMP:  return t;
      rsa_ctrl_pkg::SRC_CACHE: return c;
      rsa_ctrl_pkg::SRC_COV:   return v;
      default:                 return '0;
    endcase
  endfunction

  // sum of products followed by the finalize rule
  task automatic build_expected(input int r);
    rsa_data_pkg::data_t acc, a, b, m;
    for (int i = 0; i < X; i++) begin
      m = source_word(runs[r].m_sel, m_t[r][i], '0, m_c[r][i]);
      for (int j = 0; j < Y; j++) begin
        acc = '0;
        for (int s = 0; s < runs[r].len; s++) begin
          a = source_word(runs[r].a_sel, a_t[r][s][i], '0, a_c[r][s][i]);
          b = source_word(runs[r].b_sel, b_t[r][s][j], cache_model[j][caddr[r][s]],
                          b_c[r][s][j]);
          acc = acc + a * b;
        end
        case (runs[r].mode)
          rsa_ctrl_pkg::MODE_ADD_M: exp_c[i][r*Y+j] = m + acc;
          rsa_ctrl_pkg::MODE_SUB_M: exp_c[i][r*Y+j] = m - acc;
          default:                  exp_c[i][r*Y+j] = acc;
        endcase
      end
    end
  endtask

  // done pulse of the previous run on its own cycle
  task automatic flush_done();
    if (done_pending) begin
      @(posedge clk);
      load <= 1'b0;
      pe_ctrl.cal_en <= 1'b0;
      pe_ctrl.cal_done <= 1'b1;
      pe_ctrl.mode <= pending_mode;
      done_pending = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      load <= 1'b0;
      pe_ctrl <= '0;
    end
  endtask

  task automatic drive_run(input int r);
    bit use_cache;
    use_cache = (runs[r].b_sel == rsa_ctrl_pkg::SRC_CACHE);
    if (!runs[r].b2b) begin
      flush_done();
      idle_cycles(X + Y + 2);
    end
    // cache address leads its load by two cycles
    if (use_cache) begin
      @(posedge clk);
      cache_addr <= caddr[r][0];
      @(posedge clk);
      cache_addr <= caddr[r][1];
    end
    for (int k = 0; k <= runs[r].len; k++) begin
      @(posedge clk);
      sel.a_sel <= runs[r].a_sel;
      sel.b_sel <= runs[r].b_sel;
      sel.m_sel <= runs[r].m_sel;
      load <= (k < runs[r].len);
      if (k < runs[r].len) begin
        for (int i = 0; i < X; i++) begin
          a_temp[i] <= a_t[r][k][i];
          a_cov[i]  <= a_c[r][k][i];
          m_temp[i] <= m_t[r][i];
          m_cov[i]  <= m_c[r][i];
        end
        for (int j = 0; j < Y; j++) begin
          b_temp[j] <= b_t[r][k][j];
          b_cov[j]  <= b_c[r][k][j];
        end
      end
      if (use_cache && k + 2 < runs[r].len) begin
        cache_addr <= caddr[r][k+2];
      end
      pe_ctrl.cal_en <= (k > 0);
      pe_ctrl.cal_done <= done_pending;
      pe_ctrl.mode <= done_pending ? pending_mode : runs[r].mode;
      done_pending = 1'b0;
    end
    done_pending = 1'b1;
    pending_mode = runs[r].mode;
  endtask

  // collects every row's drain in order
  // each run is reported once all rows have it
  task automatic check_results();
    int idx [X];
    int idle, next_rep;
    bit any, ready;
    idle = 0;
    next_rep = 0;
    for (int i = 0; i < X; i++) begin
      idx[i] = 0;
    end
    while (next_rep < NRUN && idle < TIMEOUT) begin
      @(negedge clk);
      any = 1'b0;
      for (int i = 0; i < X; i++) begin
        if (c_val[i]) begin
          any = 1'b1;
          if (idx[i] < NRUN*Y) begin
            assert (c_out[i] === exp_c[i][idx[i]]) else begin
              $display("FAIL o_c[%0d] run %0d col %0d: got %h expected %h",
                       i, idx[i] / Y, idx[i] % Y, c_out[i], exp_c[i][idx[i]]);
              run_err[idx[i] / Y]++;
              errors++;
            end
            idx[i]++;
          end else begin
            $display("row %0d gave a result after all runs were drained", i);
            errors++;
          end
        end
      end
      ready = 1'b1;
      while (ready && next_rep < NRUN) begin
        for (int i = 0; i < X; i++) begin
          if (idx[i] < (next_rep + 1) * Y) ready = 1'b0;
        end
        if (ready) begin
          $display("test %0d: run %0d %s %0d steps: %s", next_rep + 2, next_rep,
                   runs[next_rep].mode.name(), runs[next_rep].len,
                   (run_err[next_rep] == 0) ? "ok" : "errors");
          if (run_err[next_rep] != 0) tests_failed++;
          next_rep++;
        end
      end
      idle = any ? 0 : idle + 1;
    end
    if (next_rep < NRUN) begin
      $display("timed out waiting for o_c_val, run %0d never completed", next_rep);
      errors++;
      tests_failed++;
    end
  endtask

  initial begin
    int rst_err;
    logic [15:0] bits;
    a_temp = '0;
    a_cov = '0;
    m_temp = '0;
    m_cov = '0;
    b_temp = '0;
    b_cov = '0;
    sel = '0;
    load = 1'b0;
    cache_we = 1'b0;
    cache_addr = '0;
    pe_ctrl = '0;
    rst_err = 0;
    runs[0] = '{rsa_ctrl_pkg::MODE_ACC,   rsa_ctrl_pkg::SRC_TEMP, rsa_ctrl_pkg::SRC_TEMP,
                rsa_ctrl_pkg::SRC_TEMP, 3, 1'b0};
    runs[1] = '{rsa_ctrl_pkg::MODE_ADD_M, rsa_ctrl_pkg::SRC_COV,  rsa_ctrl_pkg::SRC_COV,
                rsa_ctrl_pkg::SRC_COV,  3, 1'b0};
    runs[2] = '{rsa_ctrl_pkg::MODE_SUB_M, rsa_ctrl_pkg::SRC_COV,  rsa_ctrl_pkg::SRC_COV,
                rsa_ctrl_pkg::SRC_COV,  4, 1'b0};
    runs[3] = '{rsa_ctrl_pkg::MODE_ACC,   rsa_ctrl_pkg::SRC_TEMP, rsa_ctrl_pkg::SRC_CACHE,
                rsa_ctrl_pkg::SRC_TEMP, 4, 1'b0};
    runs[4] = '{rsa_ctrl_pkg::MODE_ADD_M, rsa_ctrl_pkg::SRC_ZERO, rsa_ctrl_pkg::SRC_TEMP,
                rsa_ctrl_pkg::SRC_TEMP, 2, 1'b0};
    runs[5] = '{rsa_ctrl_pkg::MODE_ACC,   rsa_ctrl_pkg::SRC_ZERO, rsa_ctrl_pkg::SRC_COV,
                rsa_ctrl_pkg::SRC_TEMP, 2, 1'b0};
    runs[6] = '{rsa_ctrl_pkg::MODE_SUB_M, rsa_ctrl_pkg::SRC_TEMP, rsa_ctrl_pkg::SRC_TEMP,
                rsa_ctrl_pkg::SRC_COV,  3, 1'b0};
    runs[7] = '{rsa_ctrl_pkg::MODE_ADD_M, rsa_ctrl_pkg::SRC_COV,  rsa_ctrl_pkg::SRC_TEMP,
                rsa_ctrl_pkg::SRC_COV,  2, 1'b1};
    runs[8] = '{rsa_ctrl_pkg::MODE_ACC,   rsa_ctrl_pkg::SRC_TEMP, rsa_ctrl_pkg::SRC_COV,
                rsa_ctrl_pkg::SRC_TEMP, 3, 1'b1};
    // cache contents first since the model reads them
    for (int j = 0; j < Y; j++) begin
      for (int a = 0; a < 2**rsa_data_pkg::CACHE_AW; a++) begin
        cache_model[j][a] = rand_word();
      end
    end
    for (int r = 0; r < NRUN; r++) begin
      run_err[r] = 0;
      for (int i = 0; i < X; i++) begin
        m_t[r][i] = rand_word();
        m_c[r][i] = rand_word();
      end
      for (int s = 0; s < MAXS; s++) begin
        bits = take_bits(3);
        caddr[r][s] = bits[2:0];
        for (int i = 0; i < X; i++) begin
          a_t[r][s][i] = rand_word();
          a_c[r][s][i] = rand_word();
        end
        for (int j = 0; j < Y; j++) begin
          b_t[r][s][j] = rand_word();
          b_c[r][s][j] = rand_word();
        end
      end
      build_expected(r);
    end

    // reset and cache fill with no results expected
    fork
      begin
        repeat (16) @(posedge clk);
        sys_rst <= 1'b0;
        for (int a = 0; a < 2**rsa_data_pkg::CACHE_AW; a++) begin
          @(posedge clk);
          cache_we <= 1'b1;
          cache_addr <= a[rsa_data_pkg::CACHE_AW-1:0];
          for (int j = 0; j < Y; j++) begin
            b_temp[j] <= cache_model[j][a];
          end
        end
        @(posedge clk);
        cache_we <= 1'b0;
      end
      repeat (26) begin
        @(negedge clk);
        assert (c_val == '0) else begin
          $display("FAIL o_c_val before first run: got %h expected %h", c_val, {X{1'b0}});
          rst_err++;
          errors++;
        end
      end
    join
    $display("test 1: reset: %s", (rst_err == 0) ? "ok" : "errors");
    if (rst_err != 0) tests_failed++;

    fork
      begin
        for (int r = 0; r < NRUN; r++) begin
          drive_run(r);
        end
        flush_done();
        idle_cycles(2);
      end
      check_results();
    join

    $display("%0d tests, %0d failed, %0d errors", NRUN + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* common/rsa_ctrl_pkg.sv */
// control encodings of the matrix core
package rsa_ctrl_pkg;

  // operand source, same code for every lane
  // A and M have no cache, they see zero there
  typedef enum logic [1:0] {
    SRC_TEMP  = 2'd0,
    SRC_CACHE = 2'd1,
    SRC_COV   = 2'd2,
    SRC_ZERO  = 2'd3
  } src_sel_e;

  // finalize opcode, applied once per run
  typedef enum logic [1:0] {
    MODE_ACC   = 2'd0,
    MODE_ADD_M = 2'd1,
    MODE_SUB_M = 2'd2
  } pe_mode_e;

  // one selector per operand
  typedef struct packed {
    src_sel_e a_sel;
    src_sel_e b_sel;
    src_sel_e m_sel;
  } operand_sel_t;

  // strobes that ride along with the operands
  typedef struct packed {
    logic     cal_en;
    logic     cal_done;
    pe_mode_e mode;
  } pe_ctrl_t;

endpackage

/* common/rsa_data_pkg.sv */
// word format and default sizes of the matrix core
package rsa_data_pkg;

  // operand and result width
  localparam int DATA_W = 16;

  // two's complement word
  // sums and products wrap modulo 2^DATA_W
  typedef logic signed [DATA_W-1:0] data_t;

  // default grid size
  // rows follow the A/M lanes, columns the B lanes
  localparam int DEF_X = 2;
  localparam int DEF_Y = 2;

  // depth of each B column cache, in address bits
  localparam int CACHE_AW = 3;

endpackage

/* pe_array/pe_array.sv */
`timescale 1ns/100ps

// skewed X by Y grid of MAC cells
module pe_array #(
  parameter int X = rsa_data_pkg::DEF_X,
  parameter int Y = rsa_data_pkg::DEF_Y
) (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  rsa_data_pkg::data_t [X-1:0] i_a,
  input  rsa_data_pkg::data_t [X-1:0] i_m,
  input  rsa_data_pkg::data_t [Y-1:0] i_b,
  input  rsa_ctrl_pkg::pe_ctrl_t      i_pe_ctrl,
  output rsa_data_pkg::data_t [X-1:0] o_c,
  output logic [X-1:0]                o_c_val
);

  // A/M run east, index Y is the unused east edge
  rsa_data_pkg::data_t    a_e    [X][Y+1];
  rsa_data_pkg::data_t    m_e    [X][Y+1];
  // drain runs west, index Y is tied off
  rsa_data_pkg::data_t    c_w    [X][Y+1];
  logic                   v_w    [X][Y+1];
  // B and strobes run north
  rsa_data_pkg::data_t    b_n    [X+1][Y];
  rsa_ctrl_pkg::pe_ctrl_t ctrl_n [X+1][Y];

  // row i delayed by i cycles
  for (genvar i = 0; i < X; i++) begin : g_row_skew
    if (i == 0) begin : g_direct
      assign a_e[0][0] = i_a[0];
      assign m_e[0][0] = i_m[0];
    end else begin : g_dly
      rsa_data_pkg::data_t a_pipe [i];
      rsa_data_pkg::data_t m_pipe [i];
      always_ff @(posedge clk) begin
        a_pipe[0] <= i_a[i];
        m_pipe[0] <= i_m[i];
        for (int k = 1; k < i; k++) begin
          a_pipe[k] <= a_pipe[k-1];
          m_pipe[k] <= m_pipe[k-1];
        end
      end
      assign a_e[i][0] = a_pipe[i-1];
      assign m_e[i][0] = m_pipe[i-1];
    end
  end

  // column j delayed by j cycles, strobes cleared on reset
  for (genvar j = 0; j < Y; j++) begin : g_col_skew
    if (j == 0) begin : g_direct
      assign b_n[0][0]    = i_b[0];
      assign ctrl_n[0][0] = i_pe_ctrl;
    end else begin : g_dly
      rsa_data_pkg::data_t    b_pipe    [j];
      rsa_ctrl_pkg::pe_ctrl_t ctrl_pipe [j];
      always_ff @(posedge clk) begin
        b_pipe[0] <= i_b[j];
        for (int k = 1; k < j; k++) begin
          b_pipe[k] <= b_pipe[k-1];
        end
      end
      always_ff @(posedge clk) begin
        if (sys_rst) begin
          for (int k = 0; k < j; k++) begin
            ctrl_pipe[k] <= '0;
          end
        end else begin
          ctrl_pipe[0] <= i_pe_ctrl;
          for (int k = 1; k < j; k++) begin
            ctrl_pipe[k] <= ctrl_pipe[k-1];
          end
        end
      end
      assign b_n[0][j]    = b_pipe[j-1];
      assign ctrl_n[0][j] = ctrl_pipe[j-1];
    end
  end

  // PE(i,j) sees everything i+j cycles late
  for (genvar i = 0; i < X; i++) begin : g_row
    assign c_w[i][Y]  = '0;
    assign v_w[i][Y]  = 1'b0;
    assign o_c[i]     = c_w[i][0];
    assign o_c_val[i] = v_w[i][0];
    for (genvar j = 0; j < Y; j++) begin : g_col
      pe_mac #(
        .LAST_COL (j == Y-1)
      ) u_pe (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .i_west_a   (a_e[i][j]),
        .i_west_m   (m_e[i][j]),
        .i_south_b  (b_n[i][j]),
        .i_ctrl     (ctrl_n[i][j]),
        .i_east_c   (c_w[i][j+1]),
        .i_east_val (v_w[i][j+1]),
        .o_east_a   (a_e[i][j+1]),
        .o_east_m   (m_e[i][j+1]),
        .o_north_b  (b_n[i+1][j]),
        .o_ctrl     (ctrl_n[i+1][j]),
        .o_c        (c_w[i][j]),
        .o_c_val    (v_w[i][j])
      );
    end
  end

endmodule

/* pe_array/pe_mac.sv */
`timescale 1ns/100ps

// one multiply-accumulate cell of the systolic grid
module pe_mac #(
  // east-edge cell, it ignores the east drain inputs
  parameter bit LAST_COL = 1'b0
) (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  rsa_data_pkg::data_t    i_west_a,
  input  rsa_data_pkg::data_t    i_west_m,
  input  rsa_data_pkg::data_t    i_south_b,
  input  rsa_ctrl_pkg::pe_ctrl_t i_ctrl,
  input  rsa_data_pkg::data_t    i_east_c,
  input  logic                   i_east_val,
  output rsa_data_pkg::data_t    o_east_a,
  output rsa_data_pkg::data_t    o_east_m,
  output rsa_data_pkg::data_t    o_north_b,
  output rsa_ctrl_pkg::pe_ctrl_t o_ctrl,
  output rsa_data_pkg::data_t    o_c,
  output logic                   o_c_val
);

  rsa_data_pkg::data_t prod;
  rsa_data_pkg::data_t acc_q;
  rsa_data_pkg::data_t result;
  rsa_data_pkg::data_t drain_q;
  logic                drain_val_q;
  // next cal_en starts a new sum
  logic                fresh_q;

  // operands step one cell east / north
  always_ff @(posedge clk) begin
    o_east_a  <= i_west_a;
    o_east_m  <= i_west_m;
    o_north_b <= i_south_b;
  end

  // strobes follow B north
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_ctrl <= '0;
    end else begin
      o_ctrl <= i_ctrl;
    end
  end

  // low word of the product only
  assign prod = i_west_a * i_south_b;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      fresh_q <= 1'b1;
    end else if (i_ctrl.cal_done) begin
      fresh_q <= 1'b1;
    end else if (i_ctrl.cal_en) begin
      fresh_q <= 1'b0;
    end
  end

  // first term overwrites, later terms add
  always_ff @(posedge clk) begin
    if (i_ctrl.cal_en) begin
      acc_q <= fresh_q ? prod : acc_q + prod;
    end
  end

  // finalize with the M word present alongside the done pulse
  always_comb begin
    case (i_ctrl.mode)
      rsa_ctrl_pkg::MODE_ADD_M: result = i_west_m + acc_q;
      rsa_ctrl_pkg::MODE_SUB_M: result = i_west_m - acc_q;
      default:                  result = acc_q;
    endcase
  end

  // drain register, apart from acc so the next run can start at once
  always_ff @(posedge clk) begin
    if (i_ctrl.cal_done) begin
      drain_q <= result;
    end
  end

  // valid for exactly one cycle after the local done
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      drain_val_q <= 1'b0;
    end else begin
      drain_val_q <= i_ctrl.cal_done;
    end
  end

  // own word wins, else the east neighbour's word passes west
  // column j fires one cycle after column j-1, so the row leaves in order
  assign o_c     = (LAST_COL || drain_val_q) ? drain_q : i_east_c;
  assign o_c_val = drain_val_q || (!LAST_COL && i_east_val);

endmodule

/* rsa_core.f */
common/rsa_data_pkg.sv
common/rsa_ctrl_pkg.sv
source/operand_select.sv
pe_array/pe_mac.sv
pe_array/pe_array.sv
source/rsa_core.sv
bench/rsa_core_assertions.sv
bench/rsa_core_tb.sv

/* source/operand_select.sv */
`timescale 1ns/100ps

// registered A/M/B source muxes in front of the PE grid
module operand_select #(
  parameter int X = rsa_data_pkg::DEF_X,
  parameter int Y = rsa_data_pkg::DEF_Y
) (
  input  logic                              clk,
  input  logic                              sys_rst,
  input  rsa_ctrl_pkg::operand_sel_t        i_sel,
  input  logic                              i_load,
  input  rsa_data_pkg::data_t [X-1:0]       i_a_temp,
  input  rsa_data_pkg::data_t [X-1:0]       i_a_cov,
  input  rsa_data_pkg::data_t [X-1:0]       i_m_temp,
  input  rsa_data_pkg::data_t [X-1:0]       i_m_cov,
  input  rsa_data_pkg::data_t [Y-1:0]       i_b_temp,
  input  rsa_data_pkg::data_t [Y-1:0]       i_b_cov,
  input  logic                              i_cache_we,
  input  logic [rsa_data_pkg::CACHE_AW-1:0] i_cache_addr,
  output rsa_data_pkg::data_t [X-1:0]       o_a,
  output rsa_data_pkg::data_t [X-1:0]       o_m,
  output rsa_data_pkg::data_t [Y-1:0]       o_b
);

  // one small ram per B column
  rsa_data_pkg::data_t cache_mem [Y][2**rsa_data_pkg::CACHE_AW];
  // raw ram read data
  rsa_data_pkg::data_t [Y-1:0] cache_rd;
  // extra output stage, two cycles from address to mux
  rsa_data_pkg::data_t [Y-1:0] cache_q;

  // four-way source pick
  // lanes without a cache pass zero as the cache word
  function automatic rsa_data_pkg::data_t pick(
    input rsa_ctrl_pkg::src_sel_e sel,
    input rsa_data_pkg::data_t    temp,
    input rsa_data_pkg::data_t    cache,
    input rsa_data_pkg::data_t    cov
  );
    case (sel)
      rsa_ctrl_pkg::SRC_TEMP:  pick = temp;
      rsa_ctrl_pkg::SRC_CACHE: pick = cache;
      rsa_ctrl_pkg::SRC_COV:   pick = cov;
      default:                 pick = '0;
    endcase
  endfunction

  // write from the temp lanes, read only when not writing
  always_ff @(posedge clk) begin
    for (int j = 0; j < Y; j++) begin
      if (i_cache_we) begin
        cache_mem[j][i_cache_addr] <= i_b_temp[j];
      end else begin
        cache_rd[j] <= cache_mem[j][i_cache_addr];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cache_q <= '0;
    end else begin
      cache_q <= cache_rd;
    end
  end

  // operand registers, hold while i_load is low
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a <= '0;
      o_m <= '0;
      o_b <= '0;
    end else if (i_load) begin
      for (int i = 0; i < X; i++) begin
        o_a[i] <= pick(i_sel.a_sel, i_a_temp[i], '0, i_a_cov[i]);
        o_m[i] <= pick(i_sel.m_sel, i_m_temp[i], '0, i_m_cov[i]);
      end
      for (int j = 0; j < Y; j++) begin
        o_b[j] <= pick(i_sel.b_sel, i_b_temp[j], cache_q[j], i_b_cov[j]);
      end
    end
  end

endmodule

/* source/rsa_core.sv */
`timescale 1ns/100ps

// matrix core, operand select feeding the systolic grid
module rsa_core #(
  parameter int X = rsa_data_pkg::DEF_X,
  parameter int Y = rsa_data_pkg::DEF_Y
) (
  input  logic                              clk,
  input  logic                              sys_rst,
  // bank lanes
  input  rsa_data_pkg::data_t [X-1:0]       i_a_temp,
  input  rsa_data_pkg::data_t [X-1:0]       i_a_cov,
  input  rsa_data_pkg::data_t [X-1:0]       i_m_temp,
  input  rsa_data_pkg::data_t [X-1:0]       i_m_cov,
  input  rsa_data_pkg::data_t [Y-1:0]       i_b_temp,
  input  rsa_data_pkg::data_t [Y-1:0]       i_b_cov,
  // operand load
  input  rsa_ctrl_pkg::operand_sel_t        i_sel,
  input  logic                              i_load,
  // B cache access
  input  logic                              i_cache_we,
  input  logic [rsa_data_pkg::CACHE_AW-1:0] i_cache_addr,
  // run strobes
  input  rsa_ctrl_pkg::pe_ctrl_t            i_pe_ctrl,
  // one drained result per row
  output rsa_data_pkg::data_t [X-1:0]       o_c,
  output logic [X-1:0]                      o_c_val
);

  // registered operands into the grid
  rsa_data_pkg::data_t [X-1:0] a_op;
  rsa_data_pkg::data_t [X-1:0] m_op;
  rsa_data_pkg::data_t [Y-1:0] b_op;

  operand_select #(
    .X (X),
    .Y (Y)
  ) u_operand_select (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_sel        (i_sel),
    .i_load       (i_load),
    .i_a_temp     (i_a_temp),
    .i_a_cov      (i_a_cov),
    .i_m_temp     (i_m_temp),
    .i_m_cov      (i_m_cov),
    .i_b_temp     (i_b_temp),
    .i_b_cov      (i_b_cov),
    .i_cache_we   (i_cache_we),
    .i_cache_addr (i_cache_addr),
    .o_a          (a_op),
    .o_m          (m_op),
    .o_b          (b_op)
  );

  pe_array #(
    .X (X),
    .Y (Y)
  ) u_pe_array (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_a       (a_op),
    .i_m       (m_op),
    .i_b       (b_op),
    .i_pe_ctrl (i_pe_ctrl),
    .o_c       (o_c),
    .o_c_val   (o_c_val)
  );

endmodule
